// ==== list.f ====
hw/fetch_pkg.sv
hw/link_readcode.sv
hw/line_reader.sv
hw/fetch_ctrl.sv
hw/code_queue.sv
hw/code_fetch_top.sv
verification/wb_code_mem.sv
verification/tb_code_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_code_fetch
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_code_fetch.sv ====
`timescale 1ns/1ps

module tb_code_fetch
    import fetch_pkg::*;
;

    localparam int     QUEUE_DEPTH    = 8;
    localparam int     CLK_PERIOD     = 40;
    localparam int     RANDOM_JUMPS   = 200;
    localparam int     NUM_JUMPS      = RANDOM_JUMPS + 16;  // Random mix plus directed jumps
    localparam int     LINES_PER_JUMP = 8;
    localparam int     LINE_CYCLES    = 64;                 // Worst case per line with stalls
    localparam longint TIMEOUT_NS     = longint'(NUM_JUMPS) * LINES_PER_JUMP
                                        * LINE_CYCLES * CLK_PERIOD;

    logic  clk          = 1'b0;
    logic  rst_n        = 1'b0;
    logic  jump_do      = 1'b0;
    addr_t jump_address = '0;
    logic  code_ready   = 1'b0;
    logic  code_valid;
    word_t code_word;
    addr_t code_addr;
    logic  wb_cyc;
    logic  wb_stb;
    addr_t wb_adr;
    word_t wb_dat_i;
    logic  wb_ack;

    int    errors     = 0;
    int    checked    = 0;
    int    since_jump = 0;                  // Handshakes since the last jump
    int    occ        = 0;                  // Queue occupancy as seen by the model
    int    acks       = 0;                  // Acks inside the current bus cycle
    int    ready_mode = 0;                  // 0 stalled, 1 always ready, 2 random stalls
    logic  cyc_prev   = 1'b0;
    logic  expect_hit = 1'b0;
    logic  hit_watch  = 1'b0;               // Line buffer hit not yet delivered
    addr_t exp_addr   = '0;
    addr_t first_adr  = '0;                 // Address of the first beat in the bus cycle

    code_fetch_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) DUT (
        .clk(clk), .rst_n(rst_n), .jump_do(jump_do), .jump_address(jump_address),
        .code_valid(code_valid), .code_word(code_word), .code_addr(code_addr),
        .code_ready(code_ready), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    wb_code_mem u_mem (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_i), .wb_ack(wb_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t expected_word(input addr_t byte_addr);
        logic [31:0] a;
        a = {2'b00, byte_addr[31:2]};
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    // Beat n of a bus cycle wraps inside the line of its first beat
    function automatic addr_t beat_address(input addr_t first, input int n);
        logic [1:0] off;
        off = first[3:2] + 2'(n);
        return {first[31:4], off, 2'b00};
    endfunction

    always @(negedge clk) begin
        case (ready_mode)
            1:       code_ready = 1'b1;
            2:       code_ready = ($urandom_range(0, 3) != 0);  // Stall about one cycle in four
            default: code_ready = 1'b0;
        endcase
    end

    // Reference model and bus checks, all on pre-edge values
    always @(posedge clk) begin
        if (rst_n) begin
            if (hit_watch) begin
                assert (!wb_stb) else begin
                    errors++;
                    $display("Bus read started before the buffered line was delivered at %0t",
                             $time);
                    hit_watch = 1'b0;
                end
            end
            if (wb_cyc && !cyc_prev) begin
                assert (occ <= QUEUE_DEPTH - 4) else begin
                    errors++;
                    $display("[FAIL] %0t occupancy at wb_cyc rise got %0d expected <= %0d",
                             $time, occ, QUEUE_DEPTH - 4);
                end
                acks      = 0;
                first_adr = wb_adr;
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                assert (wb_adr == beat_address(first_adr, acks)) else begin
                    errors++;
                    $display("[FAIL] %0t wb_adr got %h expected %h",
                             $time, wb_adr, beat_address(first_adr, acks));
                end
                acks++;
            end
            if (!wb_cyc && cyc_prev) begin
                assert (acks == 4) else begin
                    errors++;
                    $display("Bus cycle dropped after %0d acks instead of four at %0t",
                             acks, $time);
                end
            end
            if (code_valid && code_ready) begin
                assert (code_addr == exp_addr) else begin
                    errors++;
                    $display("[FAIL] %0t code_addr got %h expected %h", $time, code_addr, exp_addr);
                end
                assert (code_word == expected_word(exp_addr)) else begin
                    errors++;
                    $display("[FAIL] %0t code_word got %h expected %h",
                             $time, code_word, expected_word(exp_addr));
                end
                exp_addr = exp_addr + 32'd4;
                checked++;
                since_jump++;
                hit_watch = 1'b0;
            end
            if (jump_do) begin
                exp_addr   = {jump_address[31:2], 2'b00};   // Low bits ignored
                since_jump = 0;
                occ        = 0;                             // Flush on the jump edge
                hit_watch  = expect_hit;
            end else begin
                occ = occ + int'(DUT.push) - int'(code_valid && code_ready);
            end
            cyc_prev = wb_cyc;
        end
    end

    task automatic issue_jump(input addr_t target, input logic hit_expected);
        @(negedge clk);
        jump_do      = 1'b1;
        jump_address = target;
        expect_hit   = hit_expected;
        @(negedge clk);
        jump_do    = 1'b0;
        expect_hit = 1'b0;
    endtask

    task automatic wait_words(input int n);
        while (since_jump < n) @(negedge clk);
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;                  // Takes effect on the next falling edge
    endtask

    initial begin
        addr_t target;
        addr_t last;
        void'($urandom(32'ha9ed9397));
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        set_ready_mode(1);                  // Sequential run over several lines
        issue_jump(32'h0000_1000, 1'b0);
        wait_words(24);

        for (int off = 1; off < 4; off++) begin     // Start inside a line
            issue_jump(32'h0002_0000 + 32'h40 * off + 4 * off, 1'b0);
            wait_words(8);
        end

        for (int i = 0; i < 3; i++) begin           // Jump with a line in flight
            issue_jump(32'h0003_0000 + 32'h100 * i, 1'b0);
            while (!wb_stb) @(negedge clk);
            repeat ($urandom_range(0, 3)) @(negedge clk);
            issue_jump(32'h0004_0008 + 32'h100 * i, 1'b0);
            wait_words(12);
        end

        set_ready_mode(2);                  // Random decoder stalls
        issue_jump(32'h0005_0004, 1'b0);
        wait_words(32);

        set_ready_mode(0);                  // Fill the queue, then jump into the last line
        issue_jump(32'h0006_0000, 1'b0);
        while (wb_cyc || occ <= QUEUE_DEPTH - 4) @(negedge clk);
        repeat (3) @(negedge clk);          // Last line done lands in the buffer
        last = exp_addr + 32'(4 * (occ - 1));
        set_ready_mode(1);
        issue_jump({last[31:4], 2'($urandom_range(0, 3)), 2'b00}, 1'b1);
        wait_words(4);

        for (int n = 0; n < RANDOM_JUMPS; n++) begin
            set_ready_mode(($urandom_range(0, 3) == 0) ? 1 : 2);
            repeat ($urandom_range(0, 40)) @(negedge clk);
            if ($urandom_range(0, 1) == 1) begin
                target = exp_addr + 32'($urandom_range(0, 127)) - 32'd64;  // Near, maybe a hit
            end else begin
                target = $urandom;
            end
            issue_jump(target, 1'b0);
        end
        wait_words(8);

        $display("Run complete: %0d words checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with the run unfinished", TIMEOUT_NS);
        $display("Run stopped: %0d words checked, %0d errors", checked, errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verification/wb_code_mem.sv ====
`timescale 1ns/1ps

module wb_code_mem
    import fetch_pkg::*;
#(
    parameter int MAX_WAIT = 3                  // Longest random wait before an ack
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wb_cyc,
    input  logic  wb_stb,
    input  addr_t wb_adr,
    output word_t wb_dat_o,
    output logic  wb_ack
);

    logic ack_r     = 1'b0;
    int   wait_left = 0;                        // Wait states left in the current beat

    // Content is a fixed scramble of the word address
    function automatic word_t mem_word(input addr_t byte_addr);
        logic [31:0] a;
        a = {2'b00, byte_addr[31:2]};
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
    endfunction

    assign wb_dat_o = mem_word(wb_adr);         // Data follows the stable address
    assign wb_ack   = ack_r;

    // Ack moves on the falling edge and lasts one cycle
    always @(negedge clk) begin
        if (!rst_n || !(wb_cyc && wb_stb) || ack_r) begin
            ack_r     <= 1'b0;
            wait_left <= $urandom_range(0, MAX_WAIT);   // Fresh wait for the next beat
        end else if (wait_left == 0) begin
            ack_r <= 1'b1;
        end else begin
            wait_left <= wait_left - 1;
        end
    end

endmodule

// ==== hw/code_fetch_top.sv ====
`timescale 1ns/1ps

module code_fetch_top
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  jump_do,          // Single-cycle jump from execute
    input  addr_t jump_address,
    output logic  code_valid,       // Decoder handshake
    output word_t code_word,
    output addr_t code_addr,
    input  logic  code_ready,
    output logic  wb_cyc,           // Wishbone classic master, read only
    output logic  wb_stb,
    output addr_t wb_adr,
    input  word_t wb_dat_i,
    input  logic  wb_ack
);

    readcode_req_t                    ctrl_req;     // Controller to link
    readcode_resp_t                   ctrl_resp;
    readcode_req_t                    rd_req;       // Link to reader
    readcode_resp_t                   rd_resp;
    logic                             push;
    logic                             flush;
    code_entry_t                      push_entry;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] free;

    fetch_ctrl #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .jump_do(jump_do), .jump_address(jump_address),
        .rc_req(ctrl_req), .rc_resp(ctrl_resp),
        .push(push), .push_entry(push_entry), .flush(flush), .free(free)
    );

    link_readcode u_link (
        .clk(clk), .rst_n(rst_n),
        .req(ctrl_req), .req_resp(ctrl_resp),
        .fwd(rd_req), .fwd_resp(rd_resp)
    );

    line_reader u_reader (
        .clk(clk), .rst_n(rst_n),
        .req(rd_req), .resp(rd_resp),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    code_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .rst_n(rst_n),
        .flush(flush), .push(push), .push_entry(push_entry), .free(free),
        .code_valid(code_valid), .code_word(code_word), .code_addr(code_addr),
        .code_ready(code_ready)
    );

endmodule

// ==== hw/code_queue.sv ====
`timescale 1ns/1ps

module code_queue
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             flush,
    input  logic                             push,
    input  code_entry_t                      push_entry,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] free,
    output logic                             code_valid,
    output word_t                            code_word,
    output addr_t                            code_addr,
    input  logic                             code_ready
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    code_entry_t      mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    logic             wr_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;  // Depth need not be a power of two
    endfunction

    assign pop   = code_valid && code_ready;
    assign wr_en = push && !flush;      // Flush drops a same-cycle push

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (pop)   rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= push_entry;
    end

    assign free       = CNT_W'(QUEUE_DEPTH) - count;
    assign code_valid = (count != '0);
    assign code_word  = mem[rd_ptr].word;
    assign code_addr  = mem[rd_ptr].addr;

    // Controller must respect the free count
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != CNT_W'(QUEUE_DEPTH)));

endmodule

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             jump_do,
    input  addr_t                            jump_address,
    output readcode_req_t                    rc_req,
    input  readcode_resp_t                   rc_resp,
    output logic                             push,
    output code_entry_t                      push_entry,
    output logic                             flush,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0] free
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_state_e state;
    addr_t        ptr;                  // Next word to deliver, bits 1:0 kept zero
    logic [1:0]   rx_off;               // Offset of the incoming partial word
    logic         discard;              // Outstanding line belongs to an old target
    logic         buf_valid;
    logic [27:0]  buf_base;
    line_t        buf_line;
    logic         hit;
    logic         line_done;
    logic         rx_keep;
    logic         replay_push;

    initial begin
        if (QUEUE_DEPTH < 4) $fatal(1, "QUEUE_DEPTH must hold a full line");
    end

    assign hit       = buf_valid && (jump_address[31:4] == buf_base);
    assign line_done = (state == receive) && rc_resp.done;
    assign flush     = jump_do;             // Queue cleared on the jump edge

    // Ask only with room for a whole line, so the bus never waits on the queue
    assign rc_req.do_req  = (state == request) && (free >= CNT_W'(4));
    assign rc_req.address = ptr;

    // Words before the target offset are skipped
    assign rx_keep     = (state == receive) && !discard && rc_resp.partial_done
                         && (rx_off >= ptr[3:2]);
    assign replay_push = (state == replay) && (free != '0);
    assign push        = !jump_do && (rx_keep || replay_push);

    always_comb begin
        push_entry.word = rc_resp.partial;
        push_entry.addr = {ptr[31:4], rx_off, 2'b00};
        if (state == replay) begin
            push_entry.word = buf_line[ptr[3:2]*32 +: 32];
            push_entry.addr = ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= idle;
            discard <= 1'b0;
        end else begin
            // Set when a jump abandons an accepted line, cleared by its done
            discard <= (discard && !rc_resp.done)
                       || (jump_do && (((state == receive) && !rc_resp.done)
                                       || ((state == request) && rc_req.do_req && !discard)));
            if (jump_do) begin
                state <= hit ? replay : request;
            end else begin
                case (state)
                    request: if (rc_req.do_req && !discard) state <= receive;
                    receive: if (rc_resp.done) state <= request;
                    replay:  if (replay_push && (ptr[3:2] == 2'd3)) state <= request;
                    default: state <= idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (jump_do) begin
            ptr <= {jump_address[31:2], 2'b00};
        end else if (line_done) begin
            ptr <= {ptr[31:4] + 28'd1, 4'h0};   // On to the next line
        end else if (replay_push) begin
            ptr <= ptr + 32'd4;                 // Wraps into the next line after word 3
        end
    end

    // Offset tracks the wrapping fetch order of the reader
    always_ff @(posedge clk) begin
        if (state != receive) begin
            rx_off <= ptr[3:2];
        end else if (rc_resp.partial_done) begin
            rx_off <= rx_off + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (line_done) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_done) begin
            buf_line <= rc_resp.line;
            buf_base <= ptr[31:4];
        end
    end

endmodule

// ==== hw/line_reader.sv ====
`timescale 1ns/1ps

module line_reader
    import fetch_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  readcode_req_t  req,
    output readcode_resp_t resp,
    output logic           wb_cyc,
    output logic           wb_stb,
    output addr_t          wb_adr,
    input  word_t          wb_dat_i,
    input  logic           wb_ack
);

    logic        busy;                  // Line in progress, new requests wait
    logic [27:0] base;                  // Line address, bits 31:4
    logic [1:0]  idx;                   // Wrapping word index of the current beat
    logic [2:0]  beats;                 // Acks received so far
    logic        partial_done_r;
    logic        done_r;
    word_t       partial_r;
    line_t       line_r;
    logic        accept;
    logic        beat_end;

    assign accept   = !busy && req.do_req;
    assign beat_end = wb_stb && wb_ack;

    // Bus and handshake control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            wb_cyc         <= 1'b0;
            wb_stb         <= 1'b0;
            partial_done_r <= 1'b0;
            done_r         <= 1'b0;
        end else begin
            partial_done_r <= beat_end;                          // Word reported after its ack
            done_r         <= partial_done_r && (beats == 3'd4); // Line ends after fourth word
            if (accept) begin
                busy   <= 1'b1;
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;                                  // First beat next cycle
            end
            if (beat_end) begin
                wb_stb <= 1'b0;
                if (beats == 3'd3) begin
                    wb_cyc <= 1'b0;                              // Last ack closes the cycle
                end
            end
            if (partial_done_r && (beats != 3'd4)) begin
                wb_stb <= 1'b1;                                  // One idle cycle between beats
            end
            if (done_r) begin
                busy <= 1'b0;
            end
        end
    end

    // Address and data path
    always_ff @(posedge clk) begin
        if (accept) begin
            base  <= req.address[31:4];
            idx   <= req.address[3:2];      // Critical word first
            beats <= 3'd0;
        end
        if (beat_end) begin
            line_r[idx*32 +: 32] <= wb_dat_i;   // Word lands in its own lane
            partial_r            <= wb_dat_i;
            idx                  <= idx + 2'd1; // Wraps inside the line
            beats                <= beats + 3'd1;
        end
    end

    assign wb_adr = {base, idx, 2'b00};

    assign resp.done         = done_r;
    assign resp.line         = line_r;
    assign resp.partial      = partial_r;
    assign resp.partial_done = partial_done_r;

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc);
    a_ack_on_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> wb_stb);

endmodule

// ==== hw/link_readcode.sv ====
`timescale 1ns/1ps

module link_readcode
    import fetch_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  readcode_req_t  req,         // From the fetch controller
    output readcode_resp_t req_resp,
    output readcode_req_t  fwd,         // Toward the line reader
    input  readcode_resp_t fwd_resp
);

    logic  saved_do;                    // Request still pending at the reader
    addr_t saved_address;
    logic  save;

    // A live request is captured unless the current line ends this cycle
    assign save = req.do_req && !fwd_resp.done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saved_do <= 1'b0;
        end else if (save) begin
            saved_do <= 1'b1;
        end else if (fwd_resp.done) begin
            saved_do <= 1'b0;           // Line finished, nothing left to hold
        end
    end

    always_ff @(posedge clk) begin
        if (save) begin
            saved_address <= req.address;   // Newest request replaces the older one
        end
    end

    // Live request wins, otherwise the held copy keeps the reader fed
    assign fwd.do_req  = req.do_req || saved_do;
    assign fwd.address = req.do_req ? req.address : saved_address;

    assign req_resp = fwd_resp;         // Response passes straight back

    // A dropped request is still presented with its last live address
    a_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(req.do_req) && !req.do_req && !$past(fwd_resp.done))
            |-> (fwd.do_req && (fwd.address == $past(req.address))));

endmodule

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0]  addr_t;               // Byte address, bits 1:0 ignored
    typedef logic [31:0]  word_t;               // One code word
    typedef logic [127:0] line_t;               // Four words, word 0 in bits 31:0

    // Request from the fetch side toward the line reader
    typedef struct packed {
        logic  do_req;                          // Request strobe, held by the link
        addr_t address;                         // Address of the critical word
    } readcode_req_t;

    // Response back toward the requester
    typedef struct packed {
        logic  done;                            // Single pulse when the line is complete
        line_t line;                            // Assembled line, valid with done
        word_t partial;                         // Last fetched word
        logic  partial_done;                    // One pulse per fetched word
    } readcode_resp_t;

    // Queue entry toward the decoder
    typedef struct packed {
        word_t word;
        addr_t addr;                            // Word-aligned fetch address
    } code_entry_t;

    typedef enum logic [1:0] {
        idle,                                   // No target yet after reset
        request,                                // Asking for the pointer's line
        receive,                                // Line in flight
        replay                                  // Serving words from the line buffer
    } fetch_state_e;

endpackage
